// File: rtl/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Register and data path width
`define CSR_XLEN 32

// Full counter width, two data words
`define CSR_CNT_WIDTH 64

// Cycles from an accepted request to the done pulse
`define CSR_ACCESS_LATENCY 2

`endif

// File: rtl/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

    // Field view of a CSR address
    // Bits 11:10 give read/write access, 9:8 the lowest privilege level
    typedef struct packed {
        logic [1:0] access;
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_fields_t;

    // One address word, seen raw or split into fields
    typedef union packed {
        logic [11:0]      raw;
        csr_addr_fields_t fields;
    } csr_addr_u;

    // Access field value of a read-only CSR
    localparam logic [1:0] CSR_ACCESS_RO = 2'b11;

    // Machine scratch and counter control
    localparam logic [11:0] MSCRATCH_ADDR      = 12'h340;
    localparam logic [11:0] MCOUNTINHIBIT_ADDR = 12'h320;

    // Machine counters, low and high halves
    localparam logic [11:0] MCYCLE_ADDR    = 12'hB00;
    localparam logic [11:0] MCYCLEH_ADDR   = 12'hB80;
    localparam logic [11:0] MINSTRET_ADDR  = 12'hB02;
    localparam logic [11:0] MINSTRETH_ADDR = 12'hB82;

    // User shadows of the machine counters
    // Read-only by their access field
    localparam logic [11:0] CYCLE_ADDR    = 12'hC00;
    localparam logic [11:0] CYCLEH_ADDR   = 12'hC80;
    localparam logic [11:0] INSTRET_ADDR  = 12'hC02;
    localparam logic [11:0] INSTRETH_ADDR = 12'hC82;

endpackage

`default_nettype wire

// File: rtl/csr_op_pkg.sv
`default_nettype none

package csr_op_pkg;

    // CSR operations, encoded as their funct3
    // Bit 2 selects the immediate form
    typedef enum logic [2:0] {
        CSRRW  = 3'b001,
        CSRRS  = 3'b010,
        CSRRC  = 3'b011,
        CSRRWI = 3'b101,
        CSRRSI = 3'b110,
        CSRRCI = 3'b111
    } csr_op_e;

    // Access sequencer states
    // READ captures the old value, WRITE commits and completes
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b10
    } csr_state_e;

endpackage

`default_nettype wire

// File: rtl/csr_access_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module csr_access_fsm (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire logic                   csr_req_i,
    input  wire logic                   legal_i,
    input  wire logic                   write_req_i,
    output logic                        busy_o,
    output logic                        latch_o,
    output logic                        capture_o,
    output logic                        write_en_o,
    output logic                        done_o,
    output logic                        illegal_o,
    output csr_op_pkg::csr_state_e      state_o
);

    csr_op_pkg::csr_state_e state_q;
    csr_op_pkg::csr_state_e state_d;
    logic                   done_q;
    logic                   illegal_q;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            csr_op_pkg::IDLE: begin
                if (csr_req_i) begin
                    state_d = csr_op_pkg::READ;
                end
            end
            csr_op_pkg::READ:  state_d = csr_op_pkg::WRITE;
            csr_op_pkg::WRITE: state_d = csr_op_pkg::IDLE;
            default:           state_d = csr_op_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= csr_op_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Done and illegal registered out of READ
    // Both land in the WRITE cycle with the read data
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            done_q    <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            done_q    <= (state_q == csr_op_pkg::READ);
            illegal_q <= (state_q == csr_op_pkg::READ) && !legal_i;
        end
    end

    // Strobes only accepted when idle
    assign latch_o   = csr_req_i && (state_q == csr_op_pkg::IDLE);
    assign capture_o = (state_q == csr_op_pkg::READ);

    // Sole write decision: legal access that actually modifies
    assign write_en_o = (state_q == csr_op_pkg::WRITE) && legal_i && write_req_i;

    assign busy_o    = (state_q != csr_op_pkg::IDLE);
    assign done_o    = done_q;
    assign illegal_o = illegal_q;
    assign state_o   = state_q;

endmodule

`default_nettype wire

// File: rtl/csr_counters.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_counters (
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,
    input  wire logic                       cnt_we_i,
    input  wire logic                       cnt_sel_i,
    input  wire logic                       cnt_hi_i,
    input  wire logic [`CSR_XLEN-1:0]       cnt_wdata_i,
    input  wire logic                       inhibit_cy_i,
    input  wire logic                       inhibit_ir_i,
    input  wire logic                       retire_i,
    output logic [`CSR_CNT_WIDTH-1:0]       mcycle_o,
    output logic [`CSR_CNT_WIDTH-1:0]       minstret_o
);

    localparam logic [`CSR_CNT_WIDTH-1:0] CNT_ONE = {{(`CSR_CNT_WIDTH-1){1'b0}}, 1'b1};

    logic [`CSR_CNT_WIDTH-1:0] mcycle_q;
    logic [`CSR_CNT_WIDTH-1:0] minstret_q;
    logic                      cy_we;
    logic                      ir_we;
    logic                      cy_inc;
    logic                      ir_inc;

    // Half-word write wins over increment
    // Unwritten half holds, no carry that cycle
    function automatic logic [`CSR_CNT_WIDTH-1:0] next_count(
        input logic [`CSR_CNT_WIDTH-1:0] cur,
        input logic                      we,
        input logic                      hi,
        input logic [`CSR_XLEN-1:0]      wdata,
        input logic                      inc
    );
        logic [`CSR_CNT_WIDTH-1:0] nxt;
        nxt = cur;
        if (we) begin
            if (hi) begin
                nxt[`CSR_CNT_WIDTH-1:`CSR_XLEN] = wdata;
            end else begin
                nxt[`CSR_XLEN-1:0] = wdata;
            end
        end else if (inc) begin
            nxt = cur + CNT_ONE;
        end
        return nxt;
    endfunction

    // Select 0 is mcycle, 1 is minstret
    assign cy_we = cnt_we_i && !cnt_sel_i;
    assign ir_we = cnt_we_i && cnt_sel_i;

    // Inhibit bit 0 freezes cycles, bit 2 freezes retirements
    assign cy_inc = !inhibit_cy_i;
    assign ir_inc = retire_i && !inhibit_ir_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q   <= next_count(mcycle_q, cy_we, cnt_hi_i, cnt_wdata_i, cy_inc);
            minstret_q <= next_count(minstret_q, ir_we, cnt_hi_i, cnt_wdata_i, ir_inc);
        end
    end

    assign mcycle_o   = mcycle_q;
    assign minstret_o = minstret_q;

endmodule

`default_nettype wire

// File: rtl/csr_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_reg_file (
    input  wire logic                       clk_i,
    input  wire logic                       reset_i,
    input  wire logic                       latch_i,
    input  wire logic                       capture_i,
    input  wire logic                       write_en_i,
    input  csr_op_pkg::csr_op_e             csr_op_i,
    input  wire logic [11:0]                csr_addr_i,
    input  wire logic [`CSR_XLEN-1:0]       csr_rs1_data_i,
    input  wire logic [4:0]                 csr_zimm_i,
    input  wire logic                       csr_rs1_zero_i,
    input  wire logic [`CSR_CNT_WIDTH-1:0]  mcycle_i,
    input  wire logic [`CSR_CNT_WIDTH-1:0]  minstret_i,
    output logic                            legal_o,
    output logic                            write_req_o,
    output logic [`CSR_XLEN-1:0]            rdata_o,
    output logic                            cnt_we_o,
    output logic                            cnt_sel_o,
    output logic                            cnt_hi_o,
    output logic [`CSR_XLEN-1:0]            cnt_wdata_o,
    output logic                            inhibit_cy_o,
    output logic                            inhibit_ir_o
);

    localparam int HI = `CSR_CNT_WIDTH - 1;
    localparam int LO = `CSR_XLEN;

    // Latched request
    csr_addr_pkg::csr_addr_u addr_q;
    csr_op_pkg::csr_op_e     op_q;
    logic [`CSR_XLEN-1:0]    rs1_q;
    logic [4:0]              zimm_q;
    logic                    rs1_zero_q;

    logic [`CSR_XLEN-1:0]    mscratch_q;
    logic                    inhibit_cy_q;
    logic                    inhibit_ir_q;
    logic [`CSR_XLEN-1:0]    rdata_q;
    logic [`CSR_XLEN-1:0]    rd_val;
    logic [`CSR_XLEN-1:0]    wdata;
    logic [`CSR_XLEN-1:0]    imm_ext;
    logic                    implemented;
    logic                    read_only;
    logic                    hit_mscratch;
    logic                    hit_inhibit;
    logic                    hit_cnt;
    logic                    sel_ir;
    logic                    sel_hi;

    always_ff @(posedge clk_i) begin
        if (latch_i) begin
            addr_q.raw <= csr_addr_i;
            op_q       <= csr_op_i;
            rs1_q      <= csr_rs1_data_i;
            zimm_q     <= csr_zimm_i;
            rs1_zero_q <= csr_rs1_zero_i;
        end
    end

    // Raw view for the register match
    // Shadows share the counter decode and only ever read
    always_comb begin
        implemented  = 1'b1;
        hit_mscratch = 1'b0;
        hit_inhibit  = 1'b0;
        hit_cnt      = 1'b0;
        sel_ir       = 1'b0;
        sel_hi       = 1'b0;
        rd_val       = '0;
        case (addr_q.raw)
            csr_addr_pkg::MSCRATCH_ADDR: begin
                hit_mscratch = 1'b1;
                rd_val       = mscratch_q;
            end
            csr_addr_pkg::MCOUNTINHIBIT_ADDR: begin
                hit_inhibit = 1'b1;
                rd_val      = {{(`CSR_XLEN-3){1'b0}}, inhibit_ir_q, 1'b0, inhibit_cy_q};
            end
            csr_addr_pkg::MCYCLE_ADDR, csr_addr_pkg::CYCLE_ADDR: begin
                hit_cnt = 1'b1;
                rd_val  = mcycle_i[LO-1:0];
            end
            csr_addr_pkg::MCYCLEH_ADDR, csr_addr_pkg::CYCLEH_ADDR: begin
                hit_cnt = 1'b1;
                sel_hi  = 1'b1;
                rd_val  = mcycle_i[HI:LO];
            end
            csr_addr_pkg::MINSTRET_ADDR, csr_addr_pkg::INSTRET_ADDR: begin
                hit_cnt = 1'b1;
                sel_ir  = 1'b1;
                rd_val  = minstret_i[LO-1:0];
            end
            csr_addr_pkg::MINSTRETH_ADDR, csr_addr_pkg::INSTRETH_ADDR: begin
                hit_cnt = 1'b1;
                sel_ir  = 1'b1;
                sel_hi  = 1'b1;
                rd_val  = minstret_i[HI:LO];
            end
            default: implemented = 1'b0;
        endcase
    end

    // Field view for the read-only rule
    assign read_only = (addr_q.fields.access == csr_addr_pkg::CSR_ACCESS_RO);

    // x0 and zero-immediate set/clear leave the register alone
    assign imm_ext = {{(`CSR_XLEN-5){1'b0}}, zimm_q};

    // Merge onto the value captured in READ
    always_comb begin
        write_req_o = 1'b0;
        wdata       = rdata_q;
        case (op_q)
            csr_op_pkg::CSRRW: begin
                write_req_o = 1'b1;
                wdata       = rs1_q;
            end
            csr_op_pkg::CSRRS: begin
                write_req_o = !rs1_zero_q;
                wdata       = rdata_q | rs1_q;
            end
            csr_op_pkg::CSRRC: begin
                write_req_o = !rs1_zero_q;
                wdata       = rdata_q & ~rs1_q;
            end
            csr_op_pkg::CSRRWI: begin
                write_req_o = 1'b1;
                wdata       = imm_ext;
            end
            csr_op_pkg::CSRRSI: begin
                write_req_o = |zimm_q;
                wdata       = rdata_q | imm_ext;
            end
            csr_op_pkg::CSRRCI: begin
                write_req_o = |zimm_q;
                wdata       = rdata_q & ~imm_ext;
            end
            default: write_req_o = 1'b0;
        endcase
    end

    assign legal_o = implemented && !(read_only && write_req_o);

    // Old value held for the done cycle
    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            rdata_q <= rd_val;
        end
    end

    // Local registers, only inhibit bits 0 and 2 exist
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mscratch_q   <= '0;
            inhibit_cy_q <= 1'b0;
            inhibit_ir_q <= 1'b0;
        end else if (write_en_i) begin
            if (hit_mscratch) begin
                mscratch_q <= wdata;
            end
            if (hit_inhibit) begin
                inhibit_cy_q <= wdata[0];
                inhibit_ir_q <= wdata[2];
            end
        end
    end

    // Counter writes go out to the counter block
    assign cnt_we_o    = write_en_i && hit_cnt;
    assign cnt_sel_o   = sel_ir;
    assign cnt_hi_o    = sel_hi;
    assign cnt_wdata_o = wdata;

    assign rdata_o      = rdata_q;
    assign inhibit_cy_o = inhibit_cy_q;
    assign inhibit_ir_o = inhibit_ir_q;

endmodule

`default_nettype wire

// File: rtl/csr_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_top (
    input  wire logic                   clk_i,
    input  wire logic                   reset_i,
    input  wire logic                   csr_req_i,
    input  csr_op_pkg::csr_op_e         csr_op_i,
    input  wire logic [11:0]            csr_addr_i,
    input  wire logic [`CSR_XLEN-1:0]   csr_rs1_data_i,
    input  wire logic [4:0]             csr_zimm_i,
    input  wire logic                   csr_rs1_zero_i,
    input  wire logic                   retire_i,
    output logic                        csr_busy_o,
    output logic                        csr_done_o,
    output logic [`CSR_XLEN-1:0]        csr_rdata_o,
    output logic                        csr_illegal_o
);

    // Sequencer to register file
    logic                        latch;
    logic                        capture;
    logic                        write_en;
    logic                        legal;
    logic                        write_req;
    // Watched by the bound checker
    csr_op_pkg::csr_state_e      fsm_state;

    // Register file to counters and back
    logic                        cnt_we;
    logic                        cnt_sel;
    logic                        cnt_hi;
    logic [`CSR_XLEN-1:0]        cnt_wdata;
    logic                        inhibit_cy;
    logic                        inhibit_ir;
    logic [`CSR_CNT_WIDTH-1:0]   mcycle;
    logic [`CSR_CNT_WIDTH-1:0]   minstret;

    csr_access_fsm u_csr_access_fsm (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .csr_req_i   (csr_req_i),
        .legal_i     (legal),
        .write_req_i (write_req),
        .busy_o      (csr_busy_o),
        .latch_o     (latch),
        .capture_o   (capture),
        .write_en_o  (write_en),
        .done_o      (csr_done_o),
        .illegal_o   (csr_illegal_o),
        .state_o     (fsm_state)
    );

    csr_reg_file u_csr_reg_file (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .latch_i        (latch),
        .capture_i      (capture),
        .write_en_i     (write_en),
        .csr_op_i       (csr_op_i),
        .csr_addr_i     (csr_addr_i),
        .csr_rs1_data_i (csr_rs1_data_i),
        .csr_zimm_i     (csr_zimm_i),
        .csr_rs1_zero_i (csr_rs1_zero_i),
        .mcycle_i       (mcycle),
        .minstret_i     (minstret),
        .legal_o        (legal),
        .write_req_o    (write_req),
        .rdata_o        (csr_rdata_o),
        .cnt_we_o       (cnt_we),
        .cnt_sel_o      (cnt_sel),
        .cnt_hi_o       (cnt_hi),
        .cnt_wdata_o    (cnt_wdata),
        .inhibit_cy_o   (inhibit_cy),
        .inhibit_ir_o   (inhibit_ir)
    );

    csr_counters u_csr_counters (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .cnt_we_i     (cnt_we),
        .cnt_sel_i    (cnt_sel),
        .cnt_hi_i     (cnt_hi),
        .cnt_wdata_i  (cnt_wdata),
        .inhibit_cy_i (inhibit_cy),
        .inhibit_ir_i (inhibit_ir),
        .retire_i     (retire_i),
        .mcycle_o     (mcycle),
        .minstret_o   (minstret)
    );

endmodule

`default_nettype wire

// File: tb/csr_unit_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_assertions (
    input wire logic                   clk_i,
    input wire logic                   reset_i,
    input wire logic                   req_i,
    input wire logic                   busy_i,
    input wire logic                   done_i,
    input wire logic                   illegal_i,
    input wire logic                   write_en_i,
    input csr_op_pkg::csr_state_e      state_i
);

    logic accepted;

    // Request taken only while idle
    assign accepted = req_i && !busy_i;

    // Fixed latency from acceptance to done
    done_after_accept: assert property (
        @(posedge clk_i) disable iff (reset_i)
        accepted |-> ##(`CSR_ACCESS_LATENCY) done_i
    ) else $error("done did not follow an accepted request");

    // No done pulse without a matching request
    done_has_request: assert property (
        @(posedge clk_i) disable iff (reset_i)
        done_i |-> $past(accepted, `CSR_ACCESS_LATENCY)
    ) else $error("done pulse without an accepted request");

    // Idle without a strobe must not raise busy
    idle_not_busy: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ((state_i == csr_op_pkg::IDLE) && !req_i) |=> !busy_i
    ) else $error("busy high in IDLE");

    // Illegal access never commits
    no_write_on_illegal: assert property (
        @(posedge clk_i) disable iff (reset_i)
        illegal_i |-> !write_en_i
    ) else $error("write enable together with illegal");

endmodule

bind csr_unit_top csr_unit_assertions u_csr_unit_assertions (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (csr_req_i),
    .busy_i     (csr_busy_o),
    .done_i     (csr_done_o),
    .illegal_i  (csr_illegal_o),
    .write_en_i (write_en),
    .state_i    (fsm_state)
);

`default_nettype wire

// File: tb/csr_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_tb;

    localparam int TIMEOUT  = 20;
    localparam int MAX_ROWS = 48;

    logic                   clk_i;
    logic                   reset_i;
    logic                   csr_req_i;
    csr_op_pkg::csr_op_e    csr_op_i;
    logic [11:0]            csr_addr_i;
    logic [`CSR_XLEN-1:0]   csr_rs1_data_i;
    logic [4:0]             csr_zimm_i;
    logic                   csr_rs1_zero_i;
    logic                   retire_i;
    logic                   csr_busy_o;
    logic                   csr_done_o;
    logic [`CSR_XLEN-1:0]   csr_rdata_o;
    logic                   csr_illegal_o;

    // Stimulus table
    csr_op_pkg::csr_op_e    t_op   [MAX_ROWS];
    logic [11:0]            t_addr [MAX_ROWS];
    logic [`CSR_XLEN-1:0]   t_rs1  [MAX_ROWS];
    logic [4:0]             t_zimm [MAX_ROWS];
    logic                   t_rs1z [MAX_ROWS];
    int                     t_ret  [MAX_ROWS];
    logic                   t_chk  [MAX_ROWS];
    int                     n_rows;

    // Reference state
    logic [`CSR_XLEN-1:0]      m_scratch;
    logic [`CSR_XLEN-1:0]      m_inh;
    logic [`CSR_CNT_WIDTH-1:0] m_cy;
    logic [`CSR_CNT_WIDTH-1:0] m_ir;

    integer seed;
    int     cyc;
    int     tests;
    int     errors;

    csr_unit_top u_csr_unit_top (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .csr_req_i      (csr_req_i),
        .csr_op_i       (csr_op_i),
        .csr_addr_i     (csr_addr_i),
        .csr_rs1_data_i (csr_rs1_data_i),
        .csr_zimm_i     (csr_zimm_i),
        .csr_rs1_zero_i (csr_rs1_zero_i),
        .retire_i       (retire_i),
        .csr_busy_o     (csr_busy_o),
        .csr_done_o     (csr_done_o),
        .csr_rdata_o    (csr_rdata_o),
        .csr_illegal_o  (csr_illegal_o)
    );

    always #10 clk_i = ~clk_i;

    // Free-running edge count, marks request issue times
    always @(posedge clk_i) cyc <= cyc + 1;

    task automatic add_row(input csr_op_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] rs1, input logic [4:0] zimm,
                           input logic rs1z, input int ret, input logic chk);
        t_op[n_rows]   = op;
        t_addr[n_rows] = addr;
        t_rs1[n_rows]  = rs1;
        t_zimm[n_rows] = zimm;
        t_rs1z[n_rows] = rs1z;
        t_ret[n_rows]  = ret;
        t_chk[n_rows]  = chk;
        n_rows++;
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic pulse_retire(input int k);
        for (int i = 0; i < k; i++) begin
            @(posedge clk_i);
            retire_i <= 1'b1;
        end
        if (k > 0) begin
            @(posedge clk_i);
            retire_i <= 1'b0;
        end
    endtask

    // CSR semantics from the funct3 and address rules
    task automatic model_access(input csr_op_pkg::csr_op_e op, input logic [11:0] addr,
                                input logic [31:0] rs1, input logic [4:0] zimm,
                                input logic rs1z, output logic [31:0] rd, output logic ill);
        logic        impl;
        logic        wr;
        logic [31:0] src;
        logic [31:0] nv;
        impl = 1'b1;
        case (addr)
            12'h340:          rd = m_scratch;
            12'h320:          rd = m_inh & 32'h5;
            12'hB00, 12'hC00: rd = m_cy[31:0];
            12'hB80, 12'hC80: rd = m_cy[63:32];
            12'hB02, 12'hC02: rd = m_ir[31:0];
            12'hB82, 12'hC82: rd = m_ir[63:32];
            default: begin
                rd   = '0;
                impl = 1'b0;
            end
        endcase
        // Bit 2 of funct3 picks the immediate source
        src = op[2] ? {27'b0, zimm} : rs1;
        if (op[1:0] == 2'b01) begin
            wr = 1'b1;
            nv = src;
        end else begin
            wr = op[2] ? (zimm != 0) : !rs1z;
            nv = (op[1:0] == 2'b10) ? (rd | src) : (rd & ~src);
        end
        ill = !impl || ((addr[11:10] == 2'b11) && wr);
        if (!ill && wr) begin
            case (addr)
                12'h340: m_scratch = nv;
                12'h320: m_inh = nv & 32'h5;
                12'hB00: m_cy[31:0] = nv;
                12'hB80: m_cy[63:32] = nv;
                12'hB02: m_ir[31:0] = nv;
                12'hB82: m_ir[63:32] = nv;
                default: ;
            endcase
        end
    endtask

    // One strobe, then wait for done
    task automatic run_access(input csr_op_pkg::csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] rs1, input logic [4:0] zimm,
                              input logic rs1z, output logic [31:0] rd,
                              output logic ill, output int t);
        int w;
        @(posedge clk_i);
        csr_req_i      <= 1'b1;
        csr_op_i       <= op;
        csr_addr_i     <= addr;
        csr_rs1_data_i <= rs1;
        csr_zimm_i     <= zimm;
        csr_rs1_zero_i <= rs1z;
        t = cyc;
        @(posedge clk_i);
        csr_req_i <= 1'b0;
        w = 0;
        while (!csr_done_o && w < TIMEOUT) begin
            @(posedge clk_i);
            w++;
        end
        if (w >= TIMEOUT) give_up("done");
        rd  = csr_rdata_o;
        ill = csr_illegal_o;
    endtask

    task automatic do_row(input int id, input csr_op_pkg::csr_op_e op,
                          input logic [11:0] addr, input logic [31:0] rs1,
                          input logic [4:0] zimm, input logic rs1z,
                          input int ret, input logic chk);
        logic [31:0] exp_rd;
        logic [31:0] rd;
        logic        exp_ill;
        logic        ill;
        int          t;
        int          err0;
        err0 = errors;
        pulse_retire(ret);
        if (!m_inh[2]) m_ir = m_ir + ret;
        model_access(op, addr, rs1, zimm, rs1z, exp_rd, exp_ill);
        run_access(op, addr, rs1, zimm, rs1z, rd, ill, t);
        assert (!chk || rd == exp_rd) else begin
            $display("error: csr_rdata_o got %h expected %h", rd, exp_rd);
            errors++;
        end
        assert (ill == exp_ill) else begin
            $display("error: csr_illegal_o got %h expected %h", ill, exp_ill);
            errors++;
        end
        tests++;
        $display("row %0d addr %h: %s", id, addr, (errors == err0) ? "ok" : "mismatch");
    endtask

    task automatic check_delta(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got == want) else begin
            $display("error: %s delta got %h expected %h", name, got, want);
            errors++;
        end
        tests++;
        $display("%s delta: %s", name, (got == want) ? "ok" : "mismatch");
    endtask

    initial begin
        logic [31:0] v1;
        logic [31:0] v2;
        logic        ill;
        logic        rst_ok;
        int          t1;
        int          t2;
        int          dones;
        clk_i          = 1'b0;
        reset_i        = 1'b1;
        csr_req_i      = 1'b0;
        csr_op_i       = csr_op_pkg::CSRRS;
        csr_addr_i     = '0;
        csr_rs1_data_i = '0;
        csr_zimm_i     = '0;
        csr_rs1_zero_i = 1'b0;
        retire_i       = 1'b0;
        seed   = 37;
        cyc    = 0;
        tests  = 0;
        errors = 0;
        n_rows = 0;
        m_scratch = '0;
        m_inh     = '0;
        m_cy      = '0;
        m_ir      = '0;

        // Freeze counters, then load known halves
        add_row(csr_op_pkg::CSRRWI, 12'h320, 0, 5'h1f, 0, 0, 1);
        add_row(csr_op_pkg::CSRRW, 12'hB00, $random(seed), 0, 0, 0, 0);
        add_row(csr_op_pkg::CSRRW, 12'hB80, $random(seed), 0, 0, 0, 0);
        add_row(csr_op_pkg::CSRRW, 12'hB02, $random(seed), 0, 0, 0, 0);
        add_row(csr_op_pkg::CSRRW, 12'hB82, $random(seed), 0, 0, 0, 0);
        add_row(csr_op_pkg::CSRRS, 12'hB00, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB80, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRW, 12'hB00, $random(seed), 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB80, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB00, 0, 0, 1, 0, 1);
        // Retires while inhibited must not count
        add_row(csr_op_pkg::CSRRS, 12'hB02, 0, 0, 1, 3, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB82, 0, 0, 1, 0, 1);
        // Shadows
        add_row(csr_op_pkg::CSRRS, 12'hC00, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hC80, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRSI, 12'hC02, 0, 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hC82, 0, 0, 1, 0, 1);
        // mscratch through all six operations
        add_row(csr_op_pkg::CSRRW, 12'h340, $random(seed), 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'h340, $random(seed), 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRC, 12'h340, $random(seed), 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'h340, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRWI, 12'h340, 0, 5'h15, 0, 0, 1);
        add_row(csr_op_pkg::CSRRSI, 12'h340, 0, 5'h0a, 0, 0, 1);
        add_row(csr_op_pkg::CSRRCI, 12'h340, 0, 5'h03, 0, 0, 1);
        add_row(csr_op_pkg::CSRRCI, 12'h340, 0, 5'h00, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'h340, 0, 0, 1, 0, 1);
        // Illegal writes and unimplemented addresses
        add_row(csr_op_pkg::CSRRW, 12'hC00, $random(seed), 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hC82, 32'h1, 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRWI, 12'hC02, 0, 5'h07, 0, 0, 1);
        add_row(csr_op_pkg::CSRRW, 12'h7C0, $random(seed), 0, 0, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'h7C0, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB00, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB82, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'hB02, 0, 0, 1, 0, 1);
        add_row(csr_op_pkg::CSRRS, 12'h340, 0, 0, 1, 0, 1);

        repeat (10) @(posedge clk_i);
        reset_i <= 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            do_row(i, t_op[i], t_addr[i], t_rs1[i], t_zimm[i], t_rs1z[i], t_ret[i], t_chk[i]);
        end

        // Strobe while busy, expect one done and only the first write
        @(posedge clk_i);
        csr_req_i      <= 1'b1;
        csr_op_i       <= csr_op_pkg::CSRRW;
        csr_addr_i     <= 12'h340;
        csr_rs1_data_i <= 32'h1234_5678;
        @(posedge clk_i);
        csr_rs1_data_i <= 32'hdead_beef;
        @(posedge clk_i);
        csr_req_i <= 1'b0;
        dones = 0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_i);
            if (csr_done_o) dones++;
        end
        m_scratch = 32'h1234_5678;
        check_delta("busy strobe done count", dones, 1);
        do_row(100, csr_op_pkg::CSRRS, 12'h340, 0, 0, 1, 0, 1);

        // Free-running counters
        do_row(101, csr_op_pkg::CSRRCI, 12'h320, 0, 5'h1f, 0, 0, 1);
        run_access(csr_op_pkg::CSRRS, 12'hB00, 0, 0, 1, v1, ill, t1);
        repeat (5) @(posedge clk_i);
        run_access(csr_op_pkg::CSRRS, 12'hB00, 0, 0, 1, v2, ill, t2);
        check_delta("mcycle", v2 - v1, t2 - t1);
        run_access(csr_op_pkg::CSRRS, 12'hB02, 0, 0, 1, v1, ill, t1);
        pulse_retire(7);
        run_access(csr_op_pkg::CSRRS, 12'hB02, 0, 0, 1, v2, ill, t2);
        check_delta("minstret", v2 - v1, 7);

        // Nonzero inhibit so its reset is visible
        do_row(102, csr_op_pkg::CSRRSI, 12'h320, 0, 5'h05, 0, 0, 1);

        // Mid-run reset with an illegal access in flight
        @(posedge clk_i);
        csr_req_i      <= 1'b1;
        csr_op_i       <= csr_op_pkg::CSRRS;
        csr_addr_i     <= 12'h7C0;
        csr_rs1_zero_i <= 1'b1;
        @(posedge clk_i);
        csr_req_i <= 1'b0;
        reset_i   <= 1'b1;
        repeat (2) @(posedge clk_i);
        rst_ok = !csr_busy_o && !csr_done_o && !csr_illegal_o;
        assert (rst_ok) else begin
            $display("error: busy/done/illegal got %h%h%h expected 000",
                     csr_busy_o, csr_done_o, csr_illegal_o);
            errors++;
        end
        tests++;
        $display("reset outputs: %s", rst_ok ? "ok" : "mismatch");
        reset_i <= 1'b0;
        m_scratch = '0;
        m_inh     = '0;
        m_cy      = '0;
        m_ir      = '0;
        do_row(200, csr_op_pkg::CSRRS, 12'h340, 0, 0, 1, 0, 1);
        do_row(201, csr_op_pkg::CSRRS, 12'h320, 0, 0, 1, 0, 1);
        do_row(202, csr_op_pkg::CSRRS, 12'hB02, 0, 0, 1, 0, 1);
        do_row(203, csr_op_pkg::CSRRS, 12'hB82, 0, 0, 1, 0, 1);
        do_row(204, csr_op_pkg::CSRRS, 12'hB80, 0, 0, 1, 0, 1);

        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/csr_addr_pkg.sv
rtl/csr_op_pkg.sv
rtl/csr_access_fsm.sv
rtl/csr_counters.sv
rtl/csr_reg_file.sv
rtl/csr_unit_top.sv
tb/csr_unit_assertions.sv
tb/csr_unit_tb.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/csr_addr_pkg.sv
      - rtl/csr_op_pkg.sv
      - rtl/csr_access_fsm.sv
      - rtl/csr_counters.sv
      - rtl/csr_reg_file.sv
      - rtl/csr_unit_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/csr_unit_assertions.sv
      - tb/csr_unit_tb.sv
